//--- compile.f
+incdir+include
source/alu_pkg.sv
source/alu_operand_if.sv
source/alu_arith.sv
source/alu_shift.sv
source/ldpc_simd.sv
source/alu_wb_ctrl.sv
source/alu_top.sv
test/tb_alu_top.sv

//--- run.sh
#!/bin/sh
# Build and run the ALU testbench with Verilator, then judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_alu_top \
    -f compile.f -o Vtb_alu_top

./obj_dir/Vtb_alu_top > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
grep -q '\*\* PASS \*\*' sim.log

//--- include/alu_ref_model.svh
// Expected result and branch flag for one operation, included into the testbench module
`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

// Clamp a 9-bit lane value to the symmetric range
function automatic logic [7:0] alu_ref_sat(input logic signed [8:0] v);
    logic [7:0] r;
    if (v > alu_pkg::SAT_MAX) r = 8'(alu_pkg::SAT_MAX);
    else if (v < -alu_pkg::SAT_MAX) r = 8'(-alu_pkg::SAT_MAX);
    else r = v[7:0];
    return r;
endfunction

function automatic void alu_ref(input alu_pkg::alu_op_e op, input logic [31:0] a,
                                input logic [31:0] b, input logic [31:0] imm,
                                output logic [31:0] res, output logic flag);
    logic signed [7:0] la, lb, lc, mx, fl;
    logic [7:0]        lr;
    res  = '0;
    flag = 1'b1;
    case (op)
        alu_pkg::ADD:  res = a + b;
        alu_pkg::SUB:  res = a - b;
        alu_pkg::ANDL: res = a & b;
        alu_pkg::ORL:  res = a | b;
        alu_pkg::XORL: res = a ^ b;
        alu_pkg::ANDN: res = a & ~b;
        alu_pkg::ORN:  res = a | ~b;
        alu_pkg::XNOR: res = a ^ ~b;
        alu_pkg::SLTS: res = {31'b0, $signed(a) < $signed(b)};
        alu_pkg::SLTU: res = {31'b0, a < b};
        alu_pkg::EQ:   flag = (a == b);
        alu_pkg::NE:   flag = (a != b);
        alu_pkg::LTS:  flag = ($signed(a) < $signed(b));
        alu_pkg::LTU:  flag = (a < b);
        alu_pkg::GES:  flag = ($signed(a) >= $signed(b));
        alu_pkg::GEU:  flag = (a >= b);
        alu_pkg::SLL:  res = a << b[4:0];
        alu_pkg::SRL:  res = a >> b[4:0];
        alu_pkg::SRA:  res = $signed(a) >>> b[4:0];
        default: begin
            for (int i = 0; i < alu_pkg::LANES; i++) begin
                la = a[i*8 +: 8];
                lb = b[i*8 +: 8];
                lc = imm[i*8 +: 8];
                mx = (la >= lb) ? la : lb;
                fl = la ^ {7'b0, lb >= 0};
                case (op)
                    alu_pkg::LDPC_SIGN:        lr = {7'b0, la < 0};
                    alu_pkg::LDPC_MIN:         lr = (la >= lb) ? lb : la;
                    alu_pkg::LDPC_ABS:         lr = (la < 0) ? -la : la;
                    alu_pkg::LDPC_ADD_SAT:     lr = alu_ref_sat(9'(la) + 9'(lb));
                    alu_pkg::LDPC_SUB_SAT:     lr = alu_ref_sat(9'(la) - 9'(lb));
                    alu_pkg::LDPC_MINMAX:      lr = (lc < mx) ? lc : mx;
                    alu_pkg::LDPC_MIN_SORTING: lr = (la == lb) ? lc : la;
                    alu_pkg::LDPC_RSIGN_NMESS: lr = (fl >= 1) ? lc : -lc;
                    default:                   lr = '0;
                endcase
                res[i*8 +: 8] = lr;
            end
        end
    endcase
endfunction

`endif

//--- test/tb_alu_top.sv
// Self-checking testbench that drives the Wishbone ALU and checks every bus read against the reference model
`timescale 1ns/1ns
`default_nettype none

module tb_alu_top;

    `include "alu_ref_model.svh"

    localparam int N_RAND  = 8;
    // Operand sets per class for arith, branch, shift and LDPC
    localparam int N_OPS   = 10 * N_RAND + 6 * 8 + 3 * 8 + 8 * 12;
    localparam int N_TRANS = 6 * N_OPS + 20;
    localparam int TIMEOUT_CYCLES = 50 * N_TRANS + 200;

    localparam logic [31:0] CORNER_A [6] = '{32'h0000_0005, 32'h8000_0000, 32'h0000_0000,
                                             32'hFFFF_FFFF, 32'h0000_0000, 32'h8000_0000};
    localparam logic [31:0] CORNER_B [6] = '{32'h0000_0005, 32'h0000_0000, 32'h8000_0000,
                                             32'h0000_0000, 32'hFFFF_FFFF, 32'hFFFF_FFFF};

    logic        clk_i = 1'b0;
    logic        rst_n_i;
    logic        wb_cyc_i;
    logic        wb_stb_i;
    logic        wb_we_i;
    logic [2:0]  wb_adr_i;
    logic [31:0] wb_dat_i;
    logic [31:0] wb_dat_o;
    logic        wb_ack_o;

    // Pending checks for the compare process
    string       name_q[$];
    logic [31:0] exp_q[$];
    logic [31:0] act_q[$];
    string       chk_name;
    logic [31:0] chk_exp;
    logic [31:0] chk_act;

    alu_top alu_top_i (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o)
    );

    always #5 clk_i = ~clk_i;

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic expect_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        name_q.push_back(name);
        exp_q.push_back(exp);
        act_q.push_back(act);
    endtask

    function automatic alu_pkg::alu_op_e op_at(input int k);
        logic [4:0] v;
        v = k[4:0];
        return alu_pkg::alu_op_e'(v);
    endfunction

    // ------------------------------
    // Wishbone classic master
    // ------------------------------
    task automatic bus_xfer(input logic we, input logic [2:0] adr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
        int waited;
        @(posedge clk_i);
        expect_word("wb_ack_o idle before request", 32'd0, {31'b0, wb_ack_o});
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= we;
        wb_adr_i <= adr;
        wb_dat_i <= wdata;
        waited = 0;
        do begin
            @(posedge clk_i);
            waited++;
        end while (!wb_ack_o);
        // Request sampled on the first edge and ack seen on the second
        expect_word("wb_ack_o latency", 32'd2, 32'(waited));
        rdata = wb_dat_o;
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
    endtask

    task automatic bus_write(input logic [2:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        bus_xfer(1'b1, adr, data, unused);
    endtask

    task automatic bus_read(input logic [2:0] adr, output logic [31:0] data);
        bus_xfer(1'b0, adr, 32'd0, data);
    endtask

    task automatic run_op(input alu_pkg::alu_op_e op, input logic [31:0] a, b, c);
        logic [31:0] exp_res;
        logic [31:0] got;
        logic        exp_flag;
        alu_ref(op, a, b, c, exp_res, exp_flag);
        bus_write(alu_pkg::REG_OPA, a);
        bus_write(alu_pkg::REG_OPB, b);
        bus_write(alu_pkg::REG_IMM, c);
        bus_write(alu_pkg::REG_OP, 32'(op));
        bus_read(alu_pkg::REG_RESULT, got);
        expect_word($sformatf("REG_RESULT (%s)", op.name()), exp_res, got);
        bus_read(alu_pkg::REG_FLAG, got);
        expect_word($sformatf("REG_FLAG (%s)", op.name()), {31'b0, exp_flag}, got);
    endtask

    // ------------------------------
    // Compare process
    // ------------------------------
    always @(posedge clk_i) begin
        while (exp_q.size() > 0) begin
            chk_name = name_q.pop_front();
            chk_exp  = exp_q.pop_front();
            chk_act  = act_q.pop_front();
            assert (chk_act === chk_exp) else begin
                $display("[FAIL] %0t ns %s expected 0x%08h actual 0x%08h",
                         $time, chk_name, chk_exp, chk_act);
                abort_run("Read data did not match the expected value");
            end
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * 10);
        abort_run($sformatf("Watchdog expired after %0d cycles, the bus stopped answering",
                            TIMEOUT_CYCLES));
    end

    initial begin
        logic [31:0] a, b, c, got, exp_res;
        logic        exp_flag;
        void'($urandom(98009));
        rst_n_i  = 1'b0;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        repeat (3) @(posedge clk_i);
        rst_n_i <= 1'b1;

        // Reset state, unmapped reads and ignored writes
        bus_read(alu_pkg::REG_RESULT, got);
        expect_word("REG_RESULT after reset", 32'd0, got);
        bus_read(3'd6, got);
        expect_word("unmapped address 6", 32'd0, got);
        bus_write(alu_pkg::REG_RESULT, 32'hDEAD_BEEF);
        bus_read(alu_pkg::REG_RESULT, got);
        expect_word("REG_RESULT after write attempt", 32'd0, got);

        // First pass of the adder group hits the wrap corner
        for (int k = int'(alu_pkg::ADD); k <= int'(alu_pkg::SLTU); k++) begin
            for (int j = 0; j < N_RAND; j++) begin
                a = (j == 0) ? 32'hFFFF_FFFF : $urandom;
                b = (j == 0) ? 32'h0000_0001 : $urandom;
                run_op(op_at(k), a, b, $urandom);
            end
        end

        for (int k = int'(alu_pkg::EQ); k <= int'(alu_pkg::GEU); k++) begin
            for (int j = 0; j < 8; j++) begin
                a = (j < 6) ? CORNER_A[j] : $urandom;
                b = (j < 6) ? CORNER_B[j] : $urandom;
                run_op(op_at(k), a, b, $urandom);
            end
        end

        // Amounts 0, 31 and one with upper bits set
        for (int k = int'(alu_pkg::SLL); k <= int'(alu_pkg::SRA); k++) begin
            for (int j = 0; j < 8; j++) begin
                a = (j < 3) ? 32'h8765_4321 : $urandom;
                b = (j == 0) ? 32'd0 : (j == 1) ? 32'd31 : (j == 2) ? 32'hFFFF_FFE3 : $urandom;
                run_op(op_at(k), a, b, $urandom);
            end
        end

        for (int k = int'(alu_pkg::LDPC_SIGN); k <= int'(alu_pkg::LDPC_RSIGN_NMESS); k++) begin
            for (int j = 0; j < 12; j++) begin
                a = (j == 0) ? 32'h8081_7F00 : $urandom;
                b = (j == 0) ? 32'h7F80_017F : (j == 1) ? a : $urandom;
                c = (j == 0) ? 32'h8001_7F80 : $urandom;
                run_op(op_at(k), a, b, c);
            end
        end

        // Operand writes alone leave the result register alone
        run_op(alu_pkg::ADD, 32'd1000, 32'd234, 32'd0);
        alu_ref(alu_pkg::ADD, 32'd1000, 32'd234, 32'd0, exp_res, exp_flag);
        bus_write(alu_pkg::REG_OPA, 32'h5555_0000);
        bus_write(alu_pkg::REG_OPB, 32'h0000_1111);
        bus_read(alu_pkg::REG_RESULT, got);
        expect_word("REG_RESULT hold", exp_res, got);
        bus_write(alu_pkg::REG_OP, 32'(alu_pkg::ADD));
        alu_ref(alu_pkg::ADD, 32'h5555_0000, 32'h0000_1111, 32'd0, exp_res, exp_flag);
        bus_read(alu_pkg::REG_RESULT, got);
        expect_word("REG_RESULT after opcode rewrite", exp_res, got);
        bus_read(alu_pkg::REG_FLAG, got);
        expect_word("REG_FLAG after opcode rewrite", {31'b0, exp_flag}, got);

        repeat (2) @(posedge clk_i);
        if (exp_q.size() != 0) begin
            abort_run("Compare queue still held checks at the end of the run");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- source/alu_top.sv
// Top level joining the Wishbone controller with the arith, shift and LDPC units
`timescale 1ns/1ns
`default_nettype none

module alu_top (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       wb_cyc_i,
    input  logic                       wb_stb_i,
    input  logic                       wb_we_i,
    input  logic [alu_pkg::ADDR_W-1:0] wb_adr_i,
    input  logic [alu_pkg::XLEN-1:0]   wb_dat_i,
    output logic [alu_pkg::XLEN-1:0]   wb_dat_o,
    output logic                       wb_ack_o
);

    logic [alu_pkg::XLEN-1:0] arith_res;
    logic [alu_pkg::XLEN-1:0] shift_res;
    logic [alu_pkg::XLEN-1:0] ldpc_res;
    logic                     branch;

    alu_operand_if opnd_if ();

    alu_wb_ctrl u_ctrl (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_we_i     (wb_we_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_dat_o    (wb_dat_o),
        .wb_ack_o    (wb_ack_o),
        .opnd        (opnd_if.ctrl),
        .arith_res_i (arith_res),
        .shift_res_i (shift_res),
        .ldpc_res_i  (ldpc_res),
        .branch_i    (branch)
    );

    alu_arith u_arith (
        .opnd     (opnd_if.unit),
        .result_o (arith_res),
        .branch_o (branch)
    );

    alu_shift u_shift (
        .opnd     (opnd_if.unit),
        .result_o (shift_res)
    );

    ldpc_simd u_ldpc (
        .opnd     (opnd_if.unit),
        .result_o (ldpc_res)
    );

endmodule

`default_nettype wire

//--- source/alu_wb_ctrl.sv
// Wishbone classic slave holding operands and opcode, latches the selected unit result
`timescale 1ns/1ns
`default_nettype none

module alu_wb_ctrl (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       wb_cyc_i,
    input  logic                       wb_stb_i,
    input  logic                       wb_we_i,
    input  logic [alu_pkg::ADDR_W-1:0] wb_adr_i,
    input  logic [alu_pkg::XLEN-1:0]   wb_dat_i,
    output logic [alu_pkg::XLEN-1:0]   wb_dat_o,
    output logic                       wb_ack_o,
    alu_operand_if.ctrl                opnd,
    input  logic [alu_pkg::XLEN-1:0]   arith_res_i,
    input  logic [alu_pkg::XLEN-1:0]   shift_res_i,
    input  logic [alu_pkg::XLEN-1:0]   ldpc_res_i,
    input  logic                       branch_i
);

    logic [alu_pkg::XLEN-1:0] opa_q, opb_q, imm_q;
    logic [alu_pkg::XLEN-1:0] result_q, unit_res, rd_data;
    alu_pkg::alu_op_e         op_q;
    logic                     flag_q;
    logic                     pending_q;
    logic                     req;

    // No new request while ack is out, a held strobe gets one ack
    assign req = wb_cyc_i & wb_stb_i & ~wb_ack_o;

    assign opnd.operand_a = opa_q;
    assign opnd.operand_b = opb_q;
    assign opnd.imm       = imm_q;
    assign opnd.op        = op_q;

    // ------------------------------
    // Register writes
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            opa_q     <= '0;
            opb_q     <= '0;
            imm_q     <= '0;
            op_q      <= alu_pkg::ADD;
            pending_q <= 1'b0;
        end else begin
            pending_q <= 1'b0;
            if (req && wb_we_i) begin
                case (wb_adr_i)
                    alu_pkg::REG_OPA: opa_q <= wb_dat_i;
                    alu_pkg::REG_OPB: opb_q <= wb_dat_i;
                    alu_pkg::REG_IMM: imm_q <= wb_dat_i;
                    alu_pkg::REG_OP: begin
                        op_q      <= alu_pkg::alu_op_e'(wb_dat_i[alu_pkg::OP_W-1:0]);
                        pending_q <= 1'b1;
                    end
                    // Result, flag and unmapped addresses drop the write
                    default: ;
                endcase
            end
        end
    end

    // Datapath settles one cycle after the opcode lands
    always_comb begin
        unique case (alu_pkg::op_class_of(op_q))
            alu_pkg::ARITH: unit_res = arith_res_i;
            alu_pkg::SHIFT: unit_res = shift_res_i;
            alu_pkg::LDPC:  unit_res = ldpc_res_i;
            default:        unit_res = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            result_q <= '0;
            flag_q   <= 1'b0;
        end else if (pending_q) begin
            result_q <= unit_res;
            flag_q   <= branch_i;
        end
    end

    // ------------------------------
    // Read path and ack
    // ------------------------------
    always_comb begin
        case (wb_adr_i)
            alu_pkg::REG_OPA:    rd_data = opa_q;
            alu_pkg::REG_OPB:    rd_data = opb_q;
            alu_pkg::REG_IMM:    rd_data = imm_q;
            alu_pkg::REG_OP:     rd_data = {{(alu_pkg::XLEN-alu_pkg::OP_W){1'b0}}, op_q};
            alu_pkg::REG_RESULT: rd_data = result_q;
            alu_pkg::REG_FLAG:   rd_data = {{(alu_pkg::XLEN-1){1'b0}}, flag_q};
            default:             rd_data = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_ack_o <= 1'b0;
            wb_dat_o <= '0;
        end else begin
            wb_ack_o <= req;
            if (req && !wb_we_i) begin
                wb_dat_o <= rd_data;
            end
        end
    end

    // One ack per transfer, never back to back
    a_ack_single : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_ack_o |=> !wb_ack_o);

    a_ack_after_req : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(wb_ack_o) |-> $past(wb_cyc_i && wb_stb_i));

endmodule

`default_nettype wire

//--- source/ldpc_simd.sv
// Four signed 8-bit lanes of saturating and min-sum operations for LDPC decoding
`timescale 1ns/1ns
`default_nettype none

module ldpc_simd (
    alu_operand_if.unit              opnd,
    output logic [alu_pkg::XLEN-1:0] result_o
);

    localparam int W = alu_pkg::LANE_W;

    logic [alu_pkg::LANES-1:0][W-1:0] r_sign, r_min, r_abs, r_addsat, r_subsat;
    logic [alu_pkg::LANES-1:0][W-1:0] r_minmax, r_sort, r_rsign;

    // ------------------------------
    // Per-lane datapath
    // ------------------------------
    for (genvar i = 0; i < alu_pkg::LANES; i++) begin : g_lane
        logic signed [W-1:0] a, b, c;
        logic signed [W-1:0] mx;
        logic signed [W-1:0] flip;
        logic signed [W:0]   sum, dif;
        logic                ge;
        logic                b_pos;

        assign a = opnd.operand_a[i*W +: W];
        assign b = opnd.operand_b[i*W +: W];
        assign c = opnd.imm[i*W +: W];

        // Nine bits hold any sum or difference of two lanes
        assign sum = a + b;
        assign dif = a - b;
        assign r_addsat[i] = (sum > alu_pkg::SAT_MAX)  ? W'(alu_pkg::SAT_MAX)  :
                             (sum < -alu_pkg::SAT_MAX) ? W'(-alu_pkg::SAT_MAX) : sum[W-1:0];
        assign r_subsat[i] = (dif > alu_pkg::SAT_MAX)  ? W'(alu_pkg::SAT_MAX)  :
                             (dif < -alu_pkg::SAT_MAX) ? W'(-alu_pkg::SAT_MAX) : dif[W-1:0];

        assign ge          = (a >= b);
        assign mx          = ge ? a : b;
        assign r_min[i]    = ge ? b : a;
        assign r_minmax[i] = (c >= mx) ? mx : c;
        assign r_sort[i]   = (a == b) ? c : a;
        assign r_sign[i]   = {{(W-1){1'b0}}, a[W-1]};
        // 0x80 negates to itself
        assign r_abs[i]    = a[W-1] ? -a : a;

        // Bit 0 of a flips for a non-negative b
        assign b_pos      = ~b[W-1];
        assign flip       = a ^ {{(W-1){1'b0}}, b_pos};
        assign r_rsign[i] = (flip >= 1) ? c : -c;
    end

    always_comb begin
        case (opnd.op)
            alu_pkg::LDPC_SIGN:        result_o = r_sign;
            alu_pkg::LDPC_MIN:         result_o = r_min;
            alu_pkg::LDPC_ABS:         result_o = r_abs;
            alu_pkg::LDPC_SUB_SAT:     result_o = r_subsat;
            alu_pkg::LDPC_ADD_SAT:     result_o = r_addsat;
            alu_pkg::LDPC_MINMAX:      result_o = r_minmax;
            alu_pkg::LDPC_MIN_SORTING: result_o = r_sort;
            alu_pkg::LDPC_RSIGN_NMESS: result_o = r_rsign;
            default:                   result_o = '0;
        endcase
    end

    // Saturated results stay symmetric in every lane
    always_comb begin
        if (opnd.op == alu_pkg::LDPC_ADD_SAT || opnd.op == alu_pkg::LDPC_SUB_SAT) begin
            for (int l = 0; l < alu_pkg::LANES; l++) begin
                a_sat_range : assert ($signed(result_o[l*W +: W]) >= -alu_pkg::SAT_MAX &&
                                      $signed(result_o[l*W +: W]) <= alu_pkg::SAT_MAX)
                    else $error("LDPC lane %0d out of saturation range", l);
            end
        end
    end

endmodule

`default_nettype wire

//--- source/alu_shift.sv
// Barrel shifter, left shifts go through bit reversal around one right shifter
`timescale 1ns/1ns
`default_nettype none

module alu_shift (
    alu_operand_if.unit              opnd,
    output logic [alu_pkg::XLEN-1:0] result_o
);

    logic                     shift_left;
    logic                     shift_arith;
    logic [4:0]               shift_amt;
    logic [alu_pkg::XLEN-1:0] operand_a_rev;
    logic [alu_pkg::XLEN-1:0] shift_op;
    logic [alu_pkg::XLEN:0]   shift_op_ext;
    logic [alu_pkg::XLEN:0]   right_res;
    logic [alu_pkg::XLEN-1:0] left_res;

    assign shift_left  = (opnd.op == alu_pkg::SLL);
    assign shift_arith = (opnd.op == alu_pkg::SRA);
    assign shift_amt   = opnd.operand_b[4:0];

    for (genvar k = 0; k < alu_pkg::XLEN; k++) begin : g_rev
        assign operand_a_rev[k] = opnd.operand_a[alu_pkg::XLEN-1-k];
        assign left_res[k]      = right_res[alu_pkg::XLEN-1-k];
    end

    assign shift_op     = shift_left ? operand_a_rev : opnd.operand_a;
    // Extra top bit carries the fill value
    assign shift_op_ext = {shift_arith & shift_op[alu_pkg::XLEN-1], shift_op};
    assign right_res    = $unsigned($signed(shift_op_ext) >>> shift_amt);

    always_comb begin
        case (opnd.op)
            alu_pkg::SLL:               result_o = left_res;
            alu_pkg::SRL, alu_pkg::SRA: result_o = right_res[alu_pkg::XLEN-1:0];
            default:                    result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/alu_arith.sv
// Adder, logic, set-less-than and branch resolution, purely combinational
`timescale 1ns/1ns
`default_nettype none

module alu_arith (
    alu_operand_if.unit              opnd,
    output logic [alu_pkg::XLEN-1:0] result_o,
    output logic                     branch_o
);

    logic                     negate_b;
    logic                     sgn;
    logic                     less;
    logic                     zero;
    logic [alu_pkg::XLEN:0]   operand_b_neg;
    logic [alu_pkg::XLEN:0]   adder_ext;
    logic [alu_pkg::XLEN-1:0] adder_res;
    logic [alu_pkg::XLEN-1:0] b_mod;

    // Subtraction and the inverted logic forms share one negated b
    always_comb begin
        case (opnd.op)
            alu_pkg::SUB, alu_pkg::EQ, alu_pkg::NE,
            alu_pkg::ANDN, alu_pkg::ORN, alu_pkg::XNOR: negate_b = 1'b1;
            default: negate_b = 1'b0;
        endcase
    end

    // Carry-in rides in the extra low bit
    assign operand_b_neg = {opnd.operand_b, 1'b0} ^ {(alu_pkg::XLEN+1){negate_b}};
    assign adder_ext     = {opnd.operand_a, 1'b1} + operand_b_neg;
    assign adder_res     = adder_ext[alu_pkg::XLEN:1];
    assign b_mod         = operand_b_neg[alu_pkg::XLEN:1];
    assign zero          = ~|adder_res;

    // Signed forms extend with the sign bit, unsigned with zero
    assign sgn  = (opnd.op == alu_pkg::SLTS) || (opnd.op == alu_pkg::LTS) ||
                  (opnd.op == alu_pkg::GES);
    assign less = $signed({sgn & opnd.operand_a[alu_pkg::XLEN-1], opnd.operand_a}) <
                  $signed({sgn & opnd.operand_b[alu_pkg::XLEN-1], opnd.operand_b});

    always_comb begin
        case (opnd.op)
            alu_pkg::EQ:                 branch_o = zero;
            alu_pkg::NE:                 branch_o = ~zero;
            alu_pkg::LTS, alu_pkg::LTU:  branch_o = less;
            alu_pkg::GES, alu_pkg::GEU:  branch_o = ~less;
            default:                     branch_o = 1'b1;
        endcase
    end

    always_comb begin
        case (opnd.op)
            alu_pkg::ADD, alu_pkg::SUB:   result_o = adder_res;
            alu_pkg::ANDL, alu_pkg::ANDN: result_o = opnd.operand_a & b_mod;
            alu_pkg::ORL, alu_pkg::ORN:   result_o = opnd.operand_a | b_mod;
            alu_pkg::XORL, alu_pkg::XNOR: result_o = opnd.operand_a ^ b_mod;
            alu_pkg::SLTS, alu_pkg::SLTU: result_o = {{(alu_pkg::XLEN-1){1'b0}}, less};
            // Branch ops only produce the flag
            default:                      result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/alu_operand_if.sv
// Operand bundle from the bus controller to the combinational datapath units
`timescale 1ns/1ns
`default_nettype none

interface alu_operand_if;

    logic [alu_pkg::XLEN-1:0] operand_a;
    logic [alu_pkg::XLEN-1:0] operand_b;
    logic [alu_pkg::XLEN-1:0] imm;
    alu_pkg::alu_op_e         op;

    modport ctrl (
        output operand_a, operand_b, imm, op
    );

    modport unit (
        input operand_a, operand_b, imm, op
    );

endinterface

`default_nettype wire

//--- source/alu_pkg.sv
// Shared widths, opcodes, register map and operation classes for the Wishbone ALU
`default_nettype none

package alu_pkg;

    localparam int XLEN    = 32;
    localparam int LANE_W  = 8;
    localparam int LANES   = 4;
    localparam int SAT_MAX = 127;
    localparam int ADDR_W  = 3;
    localparam int OP_W    = 5;

    // Word addresses of the bus registers
    localparam logic [ADDR_W-1:0] REG_OPA    = 3'd0;
    localparam logic [ADDR_W-1:0] REG_OPB    = 3'd1;
    localparam logic [ADDR_W-1:0] REG_IMM    = 3'd2;
    localparam logic [ADDR_W-1:0] REG_OP     = 3'd3;
    localparam logic [ADDR_W-1:0] REG_RESULT = 3'd4;
    localparam logic [ADDR_W-1:0] REG_FLAG   = 3'd5;

    // ADD must stay at zero, reset leaves the opcode register cleared
    typedef enum logic [OP_W-1:0] {
        ADD, SUB, ANDL, ORL, XORL, ANDN, ORN, XNOR,
        SLTS, SLTU,
        EQ, NE, LTS, LTU, GES, GEU,
        SLL, SRL, SRA,
        LDPC_SIGN, LDPC_MIN, LDPC_ABS, LDPC_SUB_SAT, LDPC_ADD_SAT,
        LDPC_MINMAX, LDPC_MIN_SORTING, LDPC_RSIGN_NMESS
    } alu_op_e;

    typedef enum logic [1:0] {
        ARITH, SHIFT, LDPC, NONE
    } op_class_e;

    // Which datapath unit owns an opcode
    function automatic op_class_e op_class_of(alu_op_e op);
        op_class_e cls;
        case (op)
            ADD, SUB, ANDL, ORL, XORL, ANDN, ORN, XNOR,
            SLTS, SLTU, EQ, NE, LTS, LTU, GES, GEU: cls = ARITH;
            SLL, SRL, SRA: cls = SHIFT;
            LDPC_SIGN, LDPC_MIN, LDPC_ABS, LDPC_SUB_SAT, LDPC_ADD_SAT,
            LDPC_MINMAX, LDPC_MIN_SORTING, LDPC_RSIGN_NMESS: cls = LDPC;
            default: cls = NONE;
        endcase
        return cls;
    endfunction

endpackage

`default_nettype wire
